// ==== hdl/bp_cfg_pkg.sv ====
// predictor sizing constants and counter encoding, referenced by scoped name from every block
`default_nettype none

package bp_cfg_pkg;

    // fetch and resolve addresses are one word
    localparam int pc_bits = 32;

    // four global history states, two bits each
    localparam int hist_states = 4;
    localparam int hist_bits = 2;

    // widest table row the address struct can carry
    localparam int default_index_bits = 7;

    ////////////////////////////////////////////////////////////////////////////
    // two-bit saturating state, same code for history and pattern counters
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [hist_bits-1:0] {
        strongly_not_taken = 2'd0,
        weakly_not_taken   = 2'd1,
        weakly_taken       = 2'd2,
        strongly_taken     = 2'd3
    } pred_state_e;

    // one step toward the resolved direction, holding at either end
    function automatic pred_state_e step_toward(input pred_state_e cur, input logic outcome);
        pred_state_e nxt;
        nxt = cur;
        if (outcome && (cur != strongly_taken))
            nxt = pred_state_e'(cur + 2'd1);
        else if (!outcome && (cur != strongly_not_taken))
            nxt = pred_state_e'(cur - 2'd1);
        return nxt;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/bp_history_fsm.sv ====
// global branch history state machine, stepped once per resolved branch
`timescale 1ns/1ps
`default_nettype none

module bp_history_fsm (
    input  logic                    clk,
    input  logic                    rst,
    // predictor ready, strobes ignored otherwise
    input  logic                    enable,
    // alloc or update seen this cycle
    input  logic                    step,
    // resolved direction, 1 = taken
    input  logic                    outcome,
    output bp_cfg_pkg::pred_state_e hist
);

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////

    // starts strongly not taken after reset
    // saturating step shared with the pattern counters
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            hist <= bp_cfg_pkg::strongly_not_taken;
        end
        else if (enable && step)
        begin
            hist <= bp_cfg_pkg::step_toward(hist, outcome);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // history feeds both table columns, an X here poisons every lookup
    a_hist_known : assert property (
        @(posedge clk) disable iff (!rst)
        !$isunknown(hist)
    );

endmodule

`default_nettype wire

// ==== hdl/bp_init_sweep.sv ====
// post-reset row walker that clears the tables one index per cycle, then signals ready
`timescale 1ns/1ps
`default_nettype none

module bp_init_sweep #(
    parameter int INDEX_BITS = bp_cfg_pkg::default_index_bits
) (
    input  logic                  clk,
    input  logic                  rst,
    // row being cleared this cycle
    output logic [INDEX_BITS-1:0] row,
    // clear in progress
    output logic                  busy,
    // sweep finished, stays high until next reset
    output logic                  ready
);

    // final row of the sweep
    localparam logic [INDEX_BITS-1:0] last_row = '1;

    ////////////////////////////////////////////////////////////////////////////
    // sweep counter
    ////////////////////////////////////////////////////////////////////////////

    // row 0 is presented straight out of reset
    // one row per edge, 2**INDEX_BITS edges in all
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            row   <= '0;
            busy  <= 1'b1;
            ready <= 1'b0;
        end
        else if (busy)
        begin
            // wraps back to 0 on the last row
            row <= row + 1'b1;
            if (row == last_row)
            begin
                busy  <= 1'b0;
                ready <= 1'b1;
            end
        end
    end

    // tables take writes only once clearing is over
    a_busy_ready_excl : assert property (
        @(posedge clk) disable iff (!rst)
        !(busy && ready)
    );

endmodule

`default_nettype wire

// ==== hdl/bp_pattern_table.sv ====
// two-bit saturating pattern counters per row and history column, with the taken decision
`timescale 1ns/1ps
`default_nettype none

module bp_pattern_table #(
    parameter int INDEX_BITS = bp_cfg_pkg::default_index_bits
) (
    input  logic                     clk,
    input  logic                     rst,
    // sweep clear, one row across all columns
    input  logic                     clear,
    input  logic [INDEX_BITS-1:0]    clear_row,
    // lookup side
    input  bp_port_pkg::table_addr_t rd_addr,
    // write side, strobes already qualified by ready
    input  bp_port_pkg::table_addr_t wr_addr,
    input  bp_port_pkg::resolve_t    resolve,
    output logic                     taken,
    // counter under the lookup address
    output bp_cfg_pkg::pred_state_e  state
);

    localparam int depth = 1 << INDEX_BITS;

    bp_cfg_pkg::pred_state_e cnt_mem [depth][bp_cfg_pkg::hist_states];

    logic [INDEX_BITS-1:0] rd_row;
    logic [INDEX_BITS-1:0] wr_row;

    // counter currently held at the write address
    bp_cfg_pkg::pred_state_e wr_cur;

    assign rd_row = rd_addr.row[INDEX_BITS-1:0];
    assign wr_row = wr_addr.row[INDEX_BITS-1:0];
    assign wr_cur = cnt_mem[wr_row][wr_addr.col];

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    assign state = cnt_mem[rd_row][rd_addr.col];

    // upper half of the encoding predicts taken
    assign taken = (state == bp_cfg_pkg::weakly_taken) ||
                   (state == bp_cfg_pkg::strongly_taken);

    ////////////////////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            for (int c = 0; c < bp_cfg_pkg::hist_states; c++)
            begin
                cnt_mem[clear_row][c] <= bp_cfg_pkg::strongly_not_taken;
            end
        end
        else if (resolve.alloc)
        begin
            // fresh entry leans taken
            cnt_mem[wr_row][wr_addr.col] <= bp_cfg_pkg::weakly_taken;
        end
        else if (resolve.update)
        begin
            cnt_mem[wr_row][wr_addr.col] <= bp_cfg_pkg::step_toward(wr_cur, resolve.outcome);
        end
    end

    // sweep and top-level ready gating keep writes out of the clear phase
    a_no_write_in_clear : assert property (
        @(posedge clk) disable iff (!rst)
        clear |-> !(resolve.alloc || resolve.update)
    );

endmodule

`default_nettype wire

// ==== hdl/bp_port_pkg.sv ====
// packed structs passed between fetch, execute and the predictor tables
`default_nettype none

package bp_port_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////////////////////////////////////////

    // prediction handed back to fetch, valid in the same cycle as the pc
    typedef struct packed {
        // tag matched under current history
        logic hit;
        // counter says taken, already qualified by hit
        logic taken;
        logic [bp_cfg_pkg::pc_bits-1:0] target;
        // history state used for this lookup
        bp_cfg_pkg::pred_state_e hist;
    } fetch_pred_t;

    ////////////////////////////////////////////////////////////////////////////
    // execute side
    ////////////////////////////////////////////////////////////////////////////

    // one resolved branch, strobes are single-cycle levels
    typedef struct packed {
        // new entry, counter starts weakly taken
        logic alloc;
        // existing entry, counter steps toward outcome
        logic update;
        // 1 = taken
        logic outcome;
        logic [bp_cfg_pkg::pc_bits-1:0] pc;
        logic [bp_cfg_pkg::pc_bits-1:0] target;
    } resolve_t;

    ////////////////////////////////////////////////////////////////////////////
    // table addressing
    ////////////////////////////////////////////////////////////////////////////

    // row from pc bits 2 upward, column from global history
    // row is sized for the widest table, narrower tables use the low bits
    typedef struct packed {
        logic [bp_cfg_pkg::default_index_bits-1:0] row;
        bp_cfg_pkg::pred_state_e col;
    } table_addr_t;

endpackage

`default_nettype wire

// ==== hdl/bp_target_buffer.sv ====
// branch target buffer, tag and target per row and history column, read combinationally by fetch
`timescale 1ns/1ps
`default_nettype none

module bp_target_buffer #(
    parameter int INDEX_BITS = bp_cfg_pkg::default_index_bits
) (
    input  logic                             clk,
    input  logic                             rst,
    // sweep clear, one row across all columns
    input  logic                             clear,
    input  logic [INDEX_BITS-1:0]            clear_row,
    // lookup side
    input  bp_port_pkg::table_addr_t         rd_addr,
    input  logic [bp_cfg_pkg::pc_bits-1:0]   rd_pc,
    // write side, strobes already qualified by ready
    input  bp_port_pkg::table_addr_t         wr_addr,
    input  bp_port_pkg::resolve_t            resolve,
    output logic                             hit,
    output logic [bp_cfg_pkg::pc_bits-1:0]   target
);

    localparam int depth = 1 << INDEX_BITS;

    // odd value, never equal to a word-aligned pc
    localparam logic [bp_cfg_pkg::pc_bits-1:0] odd_tag = 1;

    logic [bp_cfg_pkg::pc_bits-1:0] tag_mem [depth][bp_cfg_pkg::hist_states];
    logic [bp_cfg_pkg::pc_bits-1:0] tgt_mem [depth][bp_cfg_pkg::hist_states];

    // narrow rows from the wide address struct
    logic [INDEX_BITS-1:0] rd_row;
    logic [INDEX_BITS-1:0] wr_row;

    assign rd_row = rd_addr.row[INDEX_BITS-1:0];
    assign wr_row = wr_addr.row[INDEX_BITS-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    // rows not yet swept may hold anything, so no hit until clearing ends
    assign hit    = !clear && (tag_mem[rd_row][rd_addr.col] == rd_pc);
    assign target = tgt_mem[rd_row][rd_addr.col];

    ////////////////////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            // targets cleared too so a miss never shows X
            for (int c = 0; c < bp_cfg_pkg::hist_states; c++)
            begin
                tag_mem[clear_row][c] <= odd_tag;
                tgt_mem[clear_row][c] <= odd_tag;
            end
        end
        else if (resolve.alloc)
        begin
            tag_mem[wr_row][wr_addr.col] <= resolve.pc;
            tgt_mem[wr_row][wr_addr.col] <= resolve.target;
        end
        else if (resolve.update && resolve.outcome)
        begin
            // not-taken update keeps the last taken target
            tgt_mem[wr_row][wr_addr.col] <= resolve.target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bp_top.sv ====
// fetch-stage branch predictor top, instantiated by the core with fetch pc in and resolves from execute
`timescale 1ns/1ps
`default_nettype none

module bp_top #(
    parameter int INDEX_BITS = 7
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [bp_cfg_pkg::pc_bits-1:0] fetch_pc,
    input  bp_port_pkg::resolve_t          resolve,
    output bp_port_pkg::fetch_pred_t       pred,
    output logic                           ready
);

    logic                     sweep_busy;
    logic [INDEX_BITS-1:0]    sweep_row;
    bp_cfg_pkg::pred_state_e  hist;
    logic                     hit;
    logic [bp_cfg_pkg::pc_bits-1:0] target;
    logic                     tbl_taken;
    bp_port_pkg::resolve_t    res_gated;
    bp_port_pkg::table_addr_t rd_addr;
    bp_port_pkg::table_addr_t wr_addr;

    ////////////////////////////////////////////////////////////////////////////
    // strobe gating and addressing
    ////////////////////////////////////////////////////////////////////////////

    // strobes dropped until the sweep is done
    always_comb
    begin
        res_gated        = resolve;
        res_gated.alloc  = resolve.alloc & ready;
        res_gated.update = resolve.update & ready;
    end

    // skip byte offset, unused high row bits stay zero
    always_comb
    begin
        rd_addr = '0;
        wr_addr = '0;
        rd_addr.row[INDEX_BITS-1:0] = fetch_pc[2 +: INDEX_BITS];
        wr_addr.row[INDEX_BITS-1:0] = resolve.pc[2 +: INDEX_BITS];
        // write column is the pre-edge history, same as the step below
        rd_addr.col = hist;
        wr_addr.col = hist;
    end

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    bp_init_sweep #(.INDEX_BITS(INDEX_BITS)) i_sweep (
        .clk(clk), .rst(rst), .row(sweep_row), .busy(sweep_busy), .ready(ready)
    );

    bp_history_fsm i_hist (
        .clk(clk), .rst(rst), .enable(ready),
        .step(resolve.alloc | resolve.update), .outcome(resolve.outcome), .hist(hist)
    );

    bp_target_buffer #(.INDEX_BITS(INDEX_BITS)) i_btb (
        .clk(clk), .rst(rst), .clear(sweep_busy), .clear_row(sweep_row),
        .rd_addr(rd_addr), .rd_pc(fetch_pc), .wr_addr(wr_addr), .resolve(res_gated),
        .hit(hit), .target(target)
    );

    // counter output left for debug probing
    bp_pattern_table #(.INDEX_BITS(INDEX_BITS)) i_pht (
        .clk(clk), .rst(rst), .clear(sweep_busy), .clear_row(sweep_row),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .resolve(res_gated),
        .taken(tbl_taken), .state()
    );

    // taken only counts on a tag match
    assign pred = '{hit: hit, taken: tbl_taken & hit, target: target, hist: hist};

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_strobe_excl : assert property (
        @(posedge clk) disable iff (!rst)
        !(resolve.alloc && resolve.update)
    );

    // row field in table_addr_t is fixed at the package width
    a_index_fits : assert property (
        @(posedge clk) INDEX_BITS <= bp_cfg_pkg::default_index_bits
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the predictor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_bp_top -f sources.f
./obj_dir/Vtb_bp_top > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

// ==== sources.f ====
hdl/bp_cfg_pkg.sv
hdl/bp_port_pkg.sv
hdl/bp_history_fsm.sv
hdl/bp_init_sweep.sv
hdl/bp_target_buffer.sv
hdl/bp_pattern_table.sv
hdl/bp_top.sv
verification/tb_bp_top.sv

// ==== verification/tb_bp_top.sv ====
// directed testbench for the branch predictor top, compiled from sources.f and run by run_sim.sh
`timescale 1ns/1ps
`default_nettype none

module tb_bp_top;

    localparam int index_bits = 7;
    localparam int depth = 1 << index_bits;
    // generous bound on the post-reset sweep
    localparam int ready_limit = 3 * depth;

    logic                           clk;
    logic                           rst;
    logic [bp_cfg_pkg::pc_bits-1:0] fetch_pc;
    bp_port_pkg::resolve_t          resolve;
    bp_port_pkg::fetch_pred_t       pred;
    logic                           ready;

    int errors;
    int checks;
    int timeouts;

    ////////////////////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////////////////////

    logic [bp_cfg_pkg::pc_bits-1:0] ref_tag [depth][bp_cfg_pkg::hist_states];
    logic [bp_cfg_pkg::pc_bits-1:0] ref_tgt [depth][bp_cfg_pkg::hist_states];
    bp_cfg_pkg::pred_state_e        ref_cnt [depth][bp_cfg_pkg::hist_states];
    bp_cfg_pkg::pred_state_e        ref_hist;

    bp_top #(.INDEX_BITS(index_bits)) i_dut (
        .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .resolve(resolve),
        .pred(pred), .ready(ready)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // clamp to the 0..3 counter range
    function automatic bp_cfg_pkg::pred_state_e saturate_step(
        input bp_cfg_pkg::pred_state_e cur, input logic taken);
        int v;
        v = int'(cur);
        v = taken ? v + 1 : v - 1;
        if (v > 3)
        begin
            v = 3;
        end
        if (v < 0)
        begin
            v = 0;
        end
        return bp_cfg_pkg::pred_state_e'(v);
    endfunction

    // word aligned, low two bits always zero
    function automatic logic [31:0] rand_aligned();
        return $urandom() & 32'hffff_fffc;
    endfunction

    function automatic bp_port_pkg::resolve_t make_resolve(input logic alloc, input logic update,
        input logic outcome, input logic [31:0] pc, input logic [31:0] target);
        bp_port_pkg::resolve_t r;
        r.alloc = alloc;
        r.update = update;
        r.outcome = outcome;
        r.pc = pc;
        r.target = target;
        return r;
    endfunction

    // state right after the sweep, tags and targets hold the odd value
    task automatic model_clear();
        for (int r = 0; r < depth; r++)
        begin
            for (int c = 0; c < bp_cfg_pkg::hist_states; c++)
            begin
                ref_tag[r][c] = 32'd1;
                ref_tgt[r][c] = 32'd1;
                ref_cnt[r][c] = bp_cfg_pkg::strongly_not_taken;
            end
        end
        ref_hist = bp_cfg_pkg::strongly_not_taken;
    endtask

    // one resolve as the next edge will see it, column is pre-edge history
    task automatic model_apply(input bp_port_pkg::resolve_t r);
        logic [index_bits-1:0] row;
        row = r.pc[2 +: index_bits];
        if (r.alloc)
        begin
            ref_tag[row][ref_hist] = r.pc;
            ref_tgt[row][ref_hist] = r.target;
            ref_cnt[row][ref_hist] = bp_cfg_pkg::weakly_taken;
        end
        else if (r.update)
        begin
            ref_cnt[row][ref_hist] = saturate_step(ref_cnt[row][ref_hist], r.outcome);
            if (r.outcome)
            begin
                ref_tgt[row][ref_hist] = r.target;
            end
        end
        if (r.alloc || r.update)
        begin
            ref_hist = saturate_step(ref_hist, r.outcome);
        end
    endtask

    function automatic bp_port_pkg::fetch_pred_t expect_pred(input logic [31:0] pc);
        bp_port_pkg::fetch_pred_t p;
        logic [index_bits-1:0] row;
        row = pc[2 +: index_bits];
        p.hist = ref_hist;
        p.hit = (ref_tag[row][ref_hist] == pc);
        // upper counter bit set means a taken prediction
        p.taken = p.hit && ref_cnt[row][ref_hist][1];
        p.target = ref_tgt[row][ref_hist];
        return p;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_pred(input string name, input bp_port_pkg::fetch_pred_t exp,
        input bp_port_pkg::fetch_pred_t act, input logic with_target);
        logic same;
        checks++;
        same = (exp.hit === act.hit) && (exp.taken === act.taken) && (exp.hist === act.hist);
        if (with_target)
        begin
            same = same && (exp.target === act.target);
        end
        if (!same)
        begin
            $display("FAILED %s: expected hit %0b taken %0b target %h hist %0d",
                     name, exp.hit, exp.taken, exp.target, exp.hist);
            $display("FAILED %s: actual   hit %0b taken %0b target %h hist %0d",
                     name, act.hit, act.taken, act.target, act.hist);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            $display("FAILED %s: expected %0b actual %0b", name, exp, act);
            errors++;
        end
    endtask

    // drive one cycle, check lookup mid-cycle, then queue the resolve in the model
    task automatic run_cycle(input string name, input bp_port_pkg::resolve_t r,
        input logic [31:0] pc);
        @(posedge clk);
        resolve <= r;
        fetch_pc <= pc;
        @(negedge clk);
        check_pred(name, expect_pred(pc), pred, 1'b1);
        model_apply(r);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    // ready exactly depth edges after release, misses all along
    task automatic test_sweep();
        int cycles;
        logic done;
        logic exp_ready;
        logic [31:0] pc;
        bp_port_pkg::fetch_pred_t miss;
        cycles = 0;
        done = 1'b0;
        miss = '0;
        miss.hist = bp_cfg_pkg::strongly_not_taken;
        model_clear();
        while (!done && cycles < ready_limit)
        begin
            @(posedge clk);
            pc = rand_aligned();
            fetch_pc <= pc;
            cycles++;
            @(negedge clk);
            exp_ready = (cycles >= depth);
            check_bit("sweep_ready", exp_ready, ready);
            if (exp_ready)
            begin
                check_pred("sweep_lookup", expect_pred(pc), pred, 1'b1);
            end
            else
            begin
                // target rows may not be cleared yet
                check_pred("sweep_lookup", miss, pred, 1'b0);
            end
            done = ready;
        end
        if (!done)
        begin
            $display("timeout: ready did not rise within %0d cycles of reset", ready_limit);
            timeouts++;
        end
    endtask

    task automatic test_alloc();
        logic [31:0] pc;
        logic [31:0] pc2;
        pc = rand_aligned();
        pc2 = rand_aligned();
        // not taken at strongly not taken keeps the column
        run_cycle("alloc_write", make_resolve(1'b1, 1'b0, 1'b0, pc, rand_aligned()), pc);
        run_cycle("alloc_hit", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), pc);
        check_bit("alloc_hit", 1'b1, pred.hit);
        // taken outcome moves history one step
        run_cycle("alloc_step", make_resolve(1'b1, 1'b0, 1'b1, pc2, rand_aligned()), pc2);
        run_cycle("alloc_step_look", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), pc2);
        run_cycle("alloc_old_col", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), pc);
    endtask

    task automatic test_counter();
        logic [31:0] scratch;
        logic [31:0] a;
        logic [31:0] b;
        scratch = rand_aligned();
        a = rand_aligned();
        b = rand_aligned();
        // park history at strongly taken
        for (int i = 0; i < 3; i++)
        begin
            run_cycle("count_warm",
                      make_resolve(1'b0, 1'b1, 1'b1, scratch, rand_aligned()), scratch);
        end
        run_cycle("count_alloc_t", make_resolve(1'b1, 1'b0, 1'b1, a, rand_aligned()), a);
        // each taken update rewrites the target
        for (int i = 0; i < 3; i++)
        begin
            run_cycle("count_taken", make_resolve(1'b0, 1'b1, 1'b1, a, rand_aligned()), a);
        end
        run_cycle("count_taken", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), a);
        // back down to strongly not taken
        for (int i = 0; i < 4; i++)
        begin
            run_cycle("count_cool",
                      make_resolve(1'b0, 1'b1, 1'b0, scratch, rand_aligned()), scratch);
        end
        run_cycle("count_alloc_nt", make_resolve(1'b1, 1'b0, 1'b0, b, rand_aligned()), b);
        // not taken keeps the old target
        for (int i = 0; i < 4; i++)
        begin
            run_cycle("count_not_taken", make_resolve(1'b0, 1'b1, 1'b0, b, rand_aligned()), b);
        end
        run_cycle("count_not_taken", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), b);
        check_bit("count_taken_off", 1'b0, pred.taken);
    endtask

    task automatic test_history();
        logic [31:0] pc;
        logic [31:0] c;
        c = rand_aligned();
        for (int i = 0; i < 6; i++)
        begin
            pc = rand_aligned();
            run_cycle("hist_up", make_resolve(1'b0, 1'b1, 1'b1, pc, rand_aligned()), pc);
        end
        for (int i = 0; i < 6; i++)
        begin
            pc = rand_aligned();
            run_cycle("hist_down", make_resolve(1'b0, 1'b1, 1'b0, pc, rand_aligned()), pc);
        end
        // written under strongly not taken, looked up under weakly not taken
        run_cycle("hist_alloc", make_resolve(1'b1, 1'b0, 1'b1, c, rand_aligned()), c);
        run_cycle("hist_moved", make_resolve(1'b0, 1'b1, 1'b0, pc, rand_aligned()), c);
        check_bit("hist_moved_miss", 1'b0, pred.hit);
        run_cycle("hist_back", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), c);
        check_bit("hist_back_hit", 1'b1, pred.hit);
    endtask

    task automatic test_random();
        logic [31:0] pool [8];
        logic [31:0] look;
        bp_port_pkg::resolve_t r;
        int kind;
        // pairs share a row with different tags
        for (int i = 0; i < 8; i++)
        begin
            pool[i] = ($urandom() & 32'hffff_fe00) | (32'(i % 4) << 2);
        end
        for (int n = 0; n < 300; n++)
        begin
            kind = $urandom() % 3;
            r = make_resolve(kind == 1, kind == 2, $urandom() % 2, pool[$urandom() % 8],
                             rand_aligned());
            look = pool[$urandom() % 8];
            run_cycle("random", r, look);
        end
        run_cycle("random_drain", make_resolve(1'b0, 1'b0, 1'b0, 0, 0), look);
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b0;
        fetch_pc = '0;
        resolve = '0;
        errors = 0;
        checks = 0;
        timeouts = 0;
        void'($urandom(32'hcdf4caf6));
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        test_sweep();
        if (timeouts == 0)
        begin
            test_alloc();
            test_counter();
            test_history();
            test_random();
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
